//--- hw/cga_params.svh
// CGA-to-VGA shared sizes
// Frame timing, sync positions, counter and RAM widths, pipeline depth
// All counts are in pixels (horizontal) or lines (vertical)

`ifndef CGA_PARAMS_SVH
`define CGA_PARAMS_SVH

// Horizontal timing in pixel clocks
`define CGA_H_ACTIVE    32
`define CGA_H_TOTAL     40
`define CGA_HSYNC_START 34
`define CGA_HSYNC_END   37

// Vertical timing in lines
`define CGA_V_ACTIVE    8
`define CGA_V_TOTAL     12
`define CGA_VSYNC_START 9
`define CGA_VSYNC_END   10

// Counter widths
`define CGA_HW          6
`define CGA_VW          4

// 64-byte video RAM
`define CGA_VRAM_AW     6

// Scan position to RGB output, in cycles
`define CGA_PIPE_DEPTH  3

`endif

//--- hw/cga_pkg.sv
// CGA-to-VGA package
// Enumerated types for video mode, lo-res palette and scan region

package cga_pkg;

    // Graphics mode from the mode register
    typedef enum logic {
        MODE_LORES = 1'b0,  // 2 bpp, palette driven
        MODE_HIRES = 1'b1   // 1 bpp, foreground color
    } cga_mode_e;

    // Lo-res palette select
    typedef enum logic {
        PAL_GRN_RED_BRN = 1'b0,
        PAL_CYN_MAG_WHT = 1'b1
    } cga_palette_e;

    // Region of a horizontal or vertical scan
    typedef enum logic [1:0] {
        REG_ACTIVE = 2'd0,
        REG_FRONT  = 2'd1,
        REG_SYNC   = 2'd2,
        REG_BACK   = 2'd3
    } cga_region_e;

endpackage

//--- hw/cga_timing.sv
// CGA scan timing
// Horizontal and vertical counters with region state machines,
// active-area flag, and active-low syncs delayed to line up with de

`timescale 1ns/1ps

`include "cga_params.svh"

module cga_timing (
    input  logic                clk,
    input  logic                rst_n,
    output logic [`CGA_HW-1:0]  hpos,
    output logic [`CGA_VW-1:0]  vpos,
    output logic                active,
    output logic                hsync,
    output logic                vsync
);
    import cga_pkg::*;

    cga_region_e h_state;
    cga_region_e v_state;
    cga_region_e h_next;
    cga_region_e v_next;
    logic        h_last;
    logic        v_last;
    logic        hs_raw;
    logic        vs_raw;
    logic [`CGA_PIPE_DEPTH-1:0] hs_pipe;
    logic [`CGA_PIPE_DEPTH-1:0] vs_pipe;

    // Region advance, shared by both axes
    // State moves on the last count of each region
    function automatic cga_region_e region_next(
        input cga_region_e state,
        input int          pos,
        input int          act_len,
        input int          sync_start,
        input int          sync_end,
        input int          total
    );
        region_next = state;
        case (state)
            REG_ACTIVE: if (pos == act_len - 1)    region_next = REG_FRONT;
            REG_FRONT:  if (pos == sync_start - 1) region_next = REG_SYNC;
            REG_SYNC:   if (pos == sync_end - 1)   region_next = REG_BACK;
            REG_BACK:   if (pos == total - 1)      region_next = REG_ACTIVE;
        endcase
    endfunction

    assign h_last = (hpos == `CGA_HW'(`CGA_H_TOTAL - 1));
    assign v_last = (vpos == `CGA_VW'(`CGA_V_TOTAL - 1));

    assign h_next = region_next(h_state, int'(hpos), `CGA_H_ACTIVE,
                                `CGA_HSYNC_START, `CGA_HSYNC_END, `CGA_H_TOTAL);
    assign v_next = region_next(v_state, int'(vpos), `CGA_V_ACTIVE,
                                `CGA_VSYNC_START, `CGA_VSYNC_END, `CGA_V_TOTAL);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hpos    <= '0;
            vpos    <= '0;
            h_state <= REG_ACTIVE;
            v_state <= REG_ACTIVE;
        end else begin
            hpos    <= h_last ? '0 : hpos + 1'b1;
            h_state <= h_next;
            // Vertical steps once per line
            if (h_last) begin
                vpos    <= v_last ? '0 : vpos + 1'b1;
                v_state <= v_next;
            end
        end
    end

    assign active = (h_state == REG_ACTIVE) && (v_state == REG_ACTIVE);

    // Raw syncs, low during the sync region
    assign hs_raw = (h_state != REG_SYNC);
    assign vs_raw = (v_state != REG_SYNC);

    // Delay line matching fetch, color and DAC stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_pipe <= '1;
            vs_pipe <= '1;
        end else begin
            hs_pipe <= {hs_pipe[`CGA_PIPE_DEPTH-2:0], hs_raw};
            vs_pipe <= {vs_pipe[`CGA_PIPE_DEPTH-2:0], vs_raw};
        end
    end

    assign hsync = hs_pipe[`CGA_PIPE_DEPTH-1];
    assign vsync = vs_pipe[`CGA_PIPE_DEPTH-1];

endmodule

//--- hw/cga_vram.sv
// CGA video RAM
// Byte-wide frame store, one write port for the host
// and one registered read port for scan-out

`timescale 1ns/1ps

`include "cga_params.svh"

module cga_vram (
    input  logic                    clk,
    input  logic                    wr_en,
    input  logic [`CGA_VRAM_AW-1:0] wr_addr,
    input  logic [7:0]              wr_data,
    input  logic [`CGA_VRAM_AW-1:0] rd_addr,
    output logic [7:0]              rd_data
);

    // 64 bytes covers one lo-res frame
    logic [7:0] mem [0:(1 << `CGA_VRAM_AW)-1];

    // Host write, any cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Scan read, one cycle latency
    // Same-address write shows up on the following read
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hw/cga_pixel_fetch.sv
// CGA pixel fetch (decode stage)
// Forms the video RAM byte address from the scan position,
// then picks the current pixel's bits out of the returned byte
// Lo-res packs 4 pixels per byte, hi-res 8, leftmost in the MSBs

`timescale 1ns/1ps

`include "cga_params.svh"

module cga_pixel_fetch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cga_pkg::cga_mode_e      mode,
    input  logic [`CGA_HW-1:0]      hpos,
    input  logic [`CGA_VW-1:0]      vpos,
    input  logic                    active,
    output logic [`CGA_VRAM_AW-1:0] rd_addr,
    input  logic [7:0]              rd_data,
    output logic [1:0]              pix_bits,
    output logic                    pix_active
);
    import cga_pkg::*;

    logic [`CGA_VRAM_AW-1:0] lores_addr;
    logic [`CGA_VRAM_AW-1:0] hires_addr;
    logic [2:0]              pos_q;
    logic                    active_q;
    logic [1:0]              lores_bits;
    logic                    hires_bit;

    // Lo-res: y * bytes per line + x / 4
    assign lores_addr = `CGA_VRAM_AW'(vpos * (`CGA_H_ACTIVE / 4) + hpos / 4);

    // Hi-res: y * bytes per line + x / 8
    assign hires_addr = `CGA_VRAM_AW'(vpos * (`CGA_H_ACTIVE / 8) + hpos / 8);

    // Address goes to the RAM in the same cycle
    always_comb begin
        case (mode)
            MODE_LORES: rd_addr = lores_addr;
            MODE_HIRES: rd_addr = hires_addr;
            default:    rd_addr = lores_addr;
        endcase
    end

    // Position within the byte, aligned with rd_data
    always_ff @(posedge clk) begin
        pos_q <= hpos[2:0];
    end

    // Active flag follows the same cycle of delay
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else begin
            active_q <= active;
        end
    end

    // Lo-res: position 0 takes bits 7:6, position 3 takes bits 1:0
    assign lores_bits = rd_data[{~pos_q[1:0], 1'b0} +: 2];

    // Hi-res: position 0 takes bit 7
    assign hires_bit = rd_data[~pos_q];

    always_comb begin
        case (mode)
            MODE_LORES: pix_bits = lores_bits;
            // Single bit sits in bit 0
            MODE_HIRES: pix_bits = {1'b0, hires_bit};
            default:    pix_bits = lores_bits;
        endcase
    end

    assign pix_active = active_q;

endmodule

//--- hw/cga_color_select.sv
// CGA color select (execute stage)
// Maps raw pixel bits to a 4-bit IRGB color index using the
// mode, palette, intensity and color register levels

`timescale 1ns/1ps

`include "cga_params.svh"

module cga_color_select (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cga_pkg::cga_mode_e     mode,
    input  cga_pkg::cga_palette_e  palette,
    input  logic                   intensity,
    input  logic [3:0]             color,
    input  logic [1:0]             pix_bits,
    input  logic                   pix_active,
    output logic [3:0]             color_idx,
    output logic                   idx_active
);
    import cga_pkg::*;

    logic       pal_sel;
    logic [3:0] idx_next;

    // Palette 1 sets the blue bit, turning green/red/brown
    // into cyan/magenta/white
    assign pal_sel = (palette == PAL_CYN_MAG_WHT);

    always_comb begin
        case (mode)
            MODE_LORES: begin
                // Pixel value 0 shows the background color
                if (pix_bits == 2'b00) begin
                    idx_next = color;
                end else begin
                    // Values 1..3 become G, R, RG (plus B on palette 1)
                    idx_next = {intensity, pix_bits, pal_sel};
                end
            end
            MODE_HIRES: begin
                // Background always black, foreground from color reg
                idx_next = pix_bits[0] ? color : 4'h0;
            end
            default: begin
                idx_next = 4'h0;
            end
        endcase
    end

    // Index register
    always_ff @(posedge clk) begin
        color_idx <= idx_next;
    end

    // Valid flag tracks the index
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx_active <= 1'b0;
        end else begin
            idx_active <= pix_active;
        end
    end

endmodule

//--- hw/cga_vgaport.sv
// CGA DAC output port (result stage)
// Converts a 4-bit IRGB index to RGB666 through the CGA color table
// and blanks outside the active area

`timescale 1ns/1ps

`include "cga_params.svh"

module cga_vgaport (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] color_idx,
    input  logic       idx_active,
    output logic [5:0] red,
    output logic [5:0] green,
    output logic [5:0] blue,
    output logic       de
);

    logic [17:0] dac_rgb;

    // Packed as {red, green, blue}
    // Normal level 2A, bright adds 15
    always_comb begin
        case (color_idx)
            4'h0: dac_rgb = {6'h00, 6'h00, 6'h00};
            4'h1: dac_rgb = {6'h00, 6'h00, 6'h2A};
            4'h2: dac_rgb = {6'h00, 6'h2A, 6'h00};
            4'h3: dac_rgb = {6'h00, 6'h2A, 6'h2A};
            4'h4: dac_rgb = {6'h2A, 6'h00, 6'h00};
            4'h5: dac_rgb = {6'h2A, 6'h00, 6'h2A};
            // Dark yellow gets half green, giving brown
            4'h6: dac_rgb = {6'h2A, 6'h15, 6'h00};
            4'h7: dac_rgb = {6'h2A, 6'h2A, 6'h2A};
            4'h8: dac_rgb = {6'h15, 6'h15, 6'h15};
            4'h9: dac_rgb = {6'h15, 6'h15, 6'h3F};
            4'hA: dac_rgb = {6'h15, 6'h3F, 6'h15};
            4'hB: dac_rgb = {6'h15, 6'h3F, 6'h3F};
            4'hC: dac_rgb = {6'h3F, 6'h15, 6'h15};
            4'hD: dac_rgb = {6'h3F, 6'h15, 6'h3F};
            4'hE: dac_rgb = {6'h3F, 6'h3F, 6'h15};
            4'hF: dac_rgb = {6'h3F, 6'h3F, 6'h3F};
            default: dac_rgb = 18'h0;
        endcase
    end

    // Output register, black outside the active area
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red   <= 6'h00;
            green <= 6'h00;
            blue  <= 6'h00;
            de    <= 1'b0;
        end else begin
            de <= idx_active;
            if (idx_active) begin
                {red, green, blue} <= dac_rgb;
            end else begin
                red   <= 6'h00;
                green <= 6'h00;
                blue  <= 6'h00;
            end
        end
    end

endmodule

//--- hw/cga_vga_top.sv
// CGA-to-VGA top level
// Host-written video RAM scanned out through fetch, color select
// and DAC stages, with syncs delayed to match

`timescale 1ns/1ps

`include "cga_params.svh"

module cga_vga_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  logic [`CGA_VRAM_AW-1:0] wr_addr,
    input  logic [7:0]              wr_data,
    input  cga_pkg::cga_mode_e      mode,
    input  cga_pkg::cga_palette_e   palette,
    input  logic                    intensity,
    input  logic [3:0]              color,
    output logic [5:0]              red,
    output logic [5:0]              green,
    output logic [5:0]              blue,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de
);

    // Scan position, cycle t
    logic [`CGA_HW-1:0]      hpos;
    logic [`CGA_VW-1:0]      vpos;
    logic                    active;

    // RAM read path
    logic [`CGA_VRAM_AW-1:0] rd_addr;
    logic [7:0]              rd_data;

    // Stage outputs, t+1 and t+2
    logic [1:0]              pix_bits;
    logic                    pix_active;
    logic [3:0]              color_idx;
    logic                    idx_active;

    cga_timing u_timing (
        .clk    (clk),
        .rst_n  (rst_n),
        .hpos   (hpos),
        .vpos   (vpos),
        .active (active),
        .hsync  (hsync),
        .vsync  (vsync)
    );

    cga_vram u_vram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    cga_pixel_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .mode       (mode),
        .hpos       (hpos),
        .vpos       (vpos),
        .active     (active),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .pix_bits   (pix_bits),
        .pix_active (pix_active)
    );

    cga_color_select u_color (
        .clk        (clk),
        .rst_n      (rst_n),
        .mode       (mode),
        .palette    (palette),
        .intensity  (intensity),
        .color      (color),
        .pix_bits   (pix_bits),
        .pix_active (pix_active),
        .color_idx  (color_idx),
        .idx_active (idx_active)
    );

    cga_vgaport u_vgaport (
        .clk        (clk),
        .rst_n      (rst_n),
        .color_idx  (color_idx),
        .idx_active (idx_active),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .de         (de)
    );

endmodule

//--- tb/cga_vga_props.sv
// CGA-to-VGA output properties
// Blanking, sync against de, and idle outputs after reset,
// bound into the top level

`timescale 1ns/1ps

module cga_vga_props (
    input logic       clk,
    input logic       rst_n,
    input logic [5:0] red,
    input logic [5:0] green,
    input logic [5:0] blue,
    input logic       hsync,
    input logic       vsync,
    input logic       de
);

    // Black outside the active area
    property p_black_when_blank;
        @(posedge clk) disable iff (!rst_n)
        !de |-> (red == 6'h00) && (green == 6'h00) && (blue == 6'h00);
    endproperty

    // Sync pulses sit in the blanking interval only
    property p_no_hsync_in_active;
        @(posedge clk) disable iff (!rst_n)
        de |-> hsync;
    endproperty

    property p_no_vsync_in_active;
        @(posedge clk) disable iff (!rst_n)
        de |-> vsync;
    endproperty

    // One cycle after a reset edge, syncs high and de low
    property p_idle_after_reset;
        @(posedge clk)
        !rst_n |=> hsync && vsync && !de;
    endproperty

    a_black_when_blank: assert property (p_black_when_blank)
        else $error("RGB is not zero while de is low");
    a_no_hsync_in_active: assert property (p_no_hsync_in_active)
        else $error("hsync is low while de is high");
    a_no_vsync_in_active: assert property (p_no_vsync_in_active)
        else $error("vsync is low while de is high");
    a_idle_after_reset: assert property (p_idle_after_reset)
        else $error("sync or de not inactive in the cycle after reset");

endmodule

bind cga_vga_top cga_vga_props u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .red   (red),
    .green (green),
    .blue  (blue),
    .hsync (hsync),
    .vsync (vsync),
    .de    (de)
);

//--- tb/cga_vga_tb.sv
// CGA-to-VGA testbench
// Directed tests for reset, both lo-res palettes, hi-res and scan timing
// Keeps its own copy of the frame and predicts every pixel from it

`timescale 1ns/1ps

`include "cga_params.svh"

module cga_vga_tb;
    import cga_pkg::*;

    localparam int FRAME_CYCLES = `CGA_H_TOTAL * `CGA_V_TOTAL;
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;
    localparam int VRAM_BYTES   = 1 << `CGA_VRAM_AW;

    logic                    clk;
    logic                    rst_n;
    logic                    wr_en;
    logic [`CGA_VRAM_AW-1:0] wr_addr;
    logic [7:0]              wr_data;
    cga_mode_e               mode;
    cga_palette_e            palette;
    logic                    intensity;
    logic [3:0]              color;
    logic [5:0]              red;
    logic [5:0]              green;
    logic [5:0]              blue;
    logic                    hsync;
    logic                    vsync;
    logic                    de;

    // Everything the host has written
    logic [7:0] frame_mem [0:VRAM_BYTES-1];

    int test_errors;
    int tests_passed;
    int tests_failed;

    cga_vga_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .mode      (mode),
        .palette   (palette),
        .intensity (intensity),
        .color     (color),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de)
    );

    // 20 ns pixel clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Inputs change and outputs are read 2 ns after the edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // Four-state compare, so an unknown output never slips through
    task automatic expect_hex(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input string where);
        assert (got === exp) else begin
            $display("FAIL %s %s: got 0x%0h, expected 0x%0h", name, where, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        test_errors++;
    endtask

    task automatic write_byte(input int addr, input logic [7:0] data);
        wr_en   = 1'b1;
        wr_addr = `CGA_VRAM_AW'(addr);
        wr_data = data;
        step();
        wr_en   = 1'b0;
        frame_mem[addr] = data;
    endtask

    // Falling vsync, seen as a high sample followed by a low one
    task automatic wait_vsync_fall(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !vsync; n++) begin
            step();
        end
        if (!vsync) begin
            report_timeout("vsync going high");
            return;
        end
        for (n = 0; n < WAIT_LIMIT && vsync; n++) begin
            step();
        end
        if (vsync) begin
            report_timeout("vsync falling");
            return;
        end
        ok = 1'b1;
    endtask

    // Returns the number of cycles stepped to reach the fall
    task automatic wait_hsync_fall(output bit ok, output int cycles);
        ok = 1'b0;
        cycles = 0;
        while (cycles < WAIT_LIMIT && !hsync) begin
            step();
            cycles++;
        end
        if (!hsync) begin
            report_timeout("hsync going high");
            return;
        end
        while (cycles < WAIT_LIMIT && hsync) begin
            step();
            cycles++;
        end
        if (hsync) begin
            report_timeout("hsync falling");
            return;
        end
        ok = 1'b1;
    endtask

    task automatic wait_de_high(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !de; n++) begin
            step();
        end
        if (!de) begin
            report_timeout("de going high");
            return;
        end
        ok = 1'b1;
    endtask

    // CGA color rules applied to the model frame
    function automatic logic [3:0] expected_index(input int x, input int y);
        logic [7:0] byte_val;
        logic [1:0] val;
        logic [3:0] idx;
        if (mode == MODE_LORES) begin
            byte_val = frame_mem[y * (`CGA_H_ACTIVE / 4) + x / 4];
            // Leftmost pixel in bits 7:6
            val = 2'((byte_val >> (6 - 2 * (x % 4))) & 8'h03);
            case (val)
                2'd0:    idx = color;
                2'd1:    idx = (palette == PAL_GRN_RED_BRN) ? 4'd2 : 4'd3;
                2'd2:    idx = (palette == PAL_GRN_RED_BRN) ? 4'd4 : 4'd5;
                default: idx = (palette == PAL_GRN_RED_BRN) ? 4'd6 : 4'd7;
            endcase
            if (val != 2'd0 && intensity) begin
                idx = idx | 4'h8;
            end
        end else begin
            byte_val = frame_mem[y * (`CGA_H_ACTIVE / 8) + x / 8];
            idx = byte_val[7 - (x % 8)] ? color : 4'h0;
        end
        return idx;
    endfunction

    // IRGB to {red, green, blue}, 2A per color bit and 15 for intensity
    function automatic logic [17:0] dac_rgb_of(input logic [3:0] idx);
        logic [5:0] base;
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
        base = idx[3] ? 6'h15 : 6'h00;
        r = base + (idx[2] ? 6'h2A : 6'h00);
        g = base + (idx[1] ? 6'h2A : 6'h00);
        b = base + (idx[0] ? 6'h2A : 6'h00);
        // Brown instead of dark yellow
        if (idx == 4'h6) begin
            g = 6'h15;
        end
        return {r, g, b};
    endfunction

    // One whole frame, pixel by pixel against the model
    task automatic scan_frame();
        bit          ok;
        int          x;
        int          y;
        logic [17:0] exp_rgb;
        string       where;
        wait_vsync_fall(ok);
        if (!ok) return;
        for (y = 0; y < `CGA_V_ACTIVE; y++) begin
            wait_de_high(ok);
            if (!ok) return;
            for (x = 0; x < `CGA_H_ACTIVE; x++) begin
                exp_rgb = dac_rgb_of(expected_index(x, y));
                where = $sformatf("at x=%0d y=%0d", x, y);
                expect_hex("de", de, 1, where);
                expect_hex("red", red, exp_rgb[17:12], where);
                expect_hex("green", green, exp_rgb[11:6], where);
                expect_hex("blue", blue, exp_rgb[5:0], where);
                step();
            end
        end
    endtask

    task automatic check_idle(input string where);
        expect_hex("hsync", hsync, 1, where);
        expect_hex("vsync", vsync, 1, where);
        expect_hex("de", de, 0, where);
        expect_hex("red", red, 0, where);
        expect_hex("green", green, 0, where);
        expect_hex("blue", blue, 0, where);
    endtask

    task automatic test_reset();
        int n;
        rst_n = 1'b0;
        for (n = 0; n < 3; n++) begin
            step();
            check_idle("during reset");
        end
        rst_n = 1'b1;
        // de comes up once the first pixel reaches the output
        for (n = 0; n < `CGA_PIPE_DEPTH - 1; n++) begin
            step();
            check_idle("after reset");
        end
    endtask

    task automatic test_lores_pal0();
        int a;
        mode      = MODE_LORES;
        palette   = PAL_GRN_RED_BRN;
        intensity = 1'b0;
        color     = 4'h1;
        for (a = 0; a < VRAM_BYTES; a++) begin
            write_byte(a, 8'($urandom));
        end
        scan_frame();
    endtask

    task automatic test_lores_pal1();
        int n;
        int a;
        palette   = PAL_CYN_MAG_WHT;
        intensity = 1'b1;
        color     = 4'h8;
        scan_frame();
        // Flip a few bytes during vertical blanking
        for (n = 0; n < 8; n++) begin
            a = $urandom_range(VRAM_BYTES - 1);
            write_byte(a, ~frame_mem[a]);
        end
        scan_frame();
    endtask

    task automatic test_hires();
        int a;
        mode      = MODE_HIRES;
        intensity = 1'b0;
        color     = 4'hF;
        for (a = 0; a < VRAM_BYTES; a++) begin
            write_byte(a, 8'((a * 37) ^ 8'h96));
        end
        scan_frame();
    endtask

    task automatic test_timing();
        bit   ok;
        bit   armed;
        int   n;
        int   cycles;
        int   run;
        int   gap;
        int   lines;
        logic prev_de;
        logic prev_hs;
        wait_hsync_fall(ok, cycles);
        if (!ok) return;
        for (n = 0; n < 4; n++) begin
            wait_hsync_fall(ok, cycles);
            if (!ok) return;
            expect_hex("hsync period", cycles, `CGA_H_TOTAL, "between falling edges");
        end
        wait_vsync_fall(ok);
        if (!ok) return;
        prev_de = de;
        prev_hs = hsync;
        armed   = 1'b0;
        run     = 0;
        gap     = 0;
        lines   = 0;
        for (n = 0; n < FRAME_CYCLES; n++) begin
            step();
            if (de) run++;
            if (armed) gap++;
            if (!prev_de && de) lines++;
            if (prev_de && !de) begin
                expect_hex("de", run, `CGA_H_ACTIVE, "high cycles per line");
                run   = 0;
                gap   = 0;
                armed = 1'b1;
            end
            // Front porch between de falling and hsync falling
            if (prev_hs && !hsync && armed) begin
                expect_hex("hsync", gap, `CGA_HSYNC_START - `CGA_H_ACTIVE,
                           "delay after de falls");
                armed = 1'b0;
            end
            prev_de = de;
            prev_hs = hsync;
        end
        expect_hex("de", lines, `CGA_V_ACTIVE, "active lines per frame");
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("PASS %s", name);
            tests_passed++;
        end else begin
            $display("Test %s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = 8'h00;
        mode         = MODE_LORES;
        palette      = PAL_GRN_RED_BRN;
        intensity    = 1'b0;
        color        = 4'h0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(32'h1acd));

        test_reset();
        end_test("reset state");
        test_lores_pal0();
        end_test("lo-res palette 0");
        test_lores_pal1();
        end_test("lo-res palette 1 bright with rewrites");
        test_hires();
        end_test("hi-res");
        test_timing();
        end_test("scan timing");

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- cga_vga.f
+incdir+hw
hw/cga_pkg.sv
hw/cga_timing.sv
hw/cga_vram.sv
hw/cga_pixel_fetch.sv
hw/cga_color_select.sv
hw/cga_vgaport.sv
hw/cga_vga_top.sv
tb/cga_vga_props.sv
tb/cga_vga_tb.sv
